// ==== Bender.yml ====
package:
  name: mole_game

export_include_dirs:
  - design

sources:
  - include_dirs:
      - design
    files:
      - design/game_pkg.sv
      - design/pixel_pkg.sv
      - design/game_control.sv
      - design/sprite_plotter.sv
      - design/mole_field.sv
      - design/frame_timer.sv
      - design/mole_game_top.sv
  - target: test
    include_dirs:
      - design
    files:
      - verification/mole_game_sva.sv
      - verification/mole_game_tb.sv

// ==== design/frame_timer.sv ====
`timescale 1ns/1ps
`include "game_settings.svh"

module frame_timer import game_pkg::*; #(
    parameter int tick_cycles = `TICK_CYCLES_DEFAULT
) (
    input  logic        clk,
    input  logic        resetn,
    input  logic        frame_run,
    input  difficulty_t difficulty,
    output logic        frame_done
);

    localparam int pre_w = $clog2(tick_cycles + 1);

    logic [pre_w-1:0] pre_cnt;
    logic [3:0]       tick_cnt;
    logic [3:0]       frame_count;
    logic             tick;

    always_comb begin
        case (difficulty)
            2'd1:    frame_count = 4'd10;
            2'd2:    frame_count = 4'd5;
            default: frame_count = 4'd15;
        endcase
    end

    assign tick = (pre_cnt == pre_w'(tick_cycles - 1));

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            pre_cnt    <= '0;
            tick_cnt   <= '0;
            frame_done <= 1'b0;
        end else if (!frame_run) begin
            pre_cnt    <= '0;
            tick_cnt   <= '0;
            frame_done <= 1'b0;
        end else begin
            frame_done <= tick && (tick_cnt == frame_count - 4'd1);
            if (tick) begin
                pre_cnt <= '0;
                if (tick_cnt != frame_count) begin
                    tick_cnt <= tick_cnt + 4'd1;  // saturates, single done pulse
                end
            end else begin
                pre_cnt <= pre_cnt + 1'b1;
            end
        end
    end

endmodule

// ==== design/game_control.sv ====
`timescale 1ns/1ps

module game_control import game_pkg::*; (
    input  logic     clk,
    input  logic     resetn,
    input  logic     go,
    input  logic     draw_ack,
    input  logic     frame_done,
    output logic     draw_req,
    output draw_op_t draw_op,
    output slot_t    draw_slot,
    output logic     update,
    output logic     frame_run
);

    ctrl_state_t state;

    assign draw_req  = (state == st_issue);
    assign update    = (state == st_update);
    assign frame_run = (state == st_frame);

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            state     <= st_boot;
            draw_op   <= op_clear;  // first command after reset
            draw_slot <= '0;
        end else begin
            case (state)
                st_boot: begin
                    state <= st_issue;
                end
                st_issue: begin
                    if (draw_ack) begin
                        // the last mole's release is spent inside the frame wait
                        if (draw_op == op_mole && draw_slot == 2'd3) begin
                            state <= st_frame;
                        end else begin
                            state <= st_release;
                        end
                    end
                end
                st_release: begin
                    if (!draw_ack) begin
                        if (draw_op == op_clear) begin
                            state <= st_idle;
                        end else if (draw_slot != 2'd3) begin
                            draw_slot <= draw_slot + 2'd1;  // next hole, same shape
                            state     <= st_issue;
                        end else if (draw_op == op_erase) begin
                            state <= st_update;
                        end else begin
                            draw_op   <= op_mole;           // next round
                            draw_slot <= '0;
                            state     <= st_issue;
                        end
                    end
                end
                st_idle: begin
                    if (go) begin
                        draw_op   <= op_mole;
                        draw_slot <= '0;
                        state     <= st_issue;
                    end
                end
                st_frame: begin
                    if (frame_done) begin
                        draw_op   <= op_erase;
                        draw_slot <= '0;
                        state     <= st_issue;
                    end
                end
                st_update: begin
                    draw_op   <= op_hammer;
                    draw_slot <= '0;
                    state     <= st_issue;
                end
                default: begin
                    state <= st_boot;
                end
            endcase
        end
    end

endmodule

// ==== design/game_pkg.sv ====
package game_pkg;

    // round sequencer states
    typedef enum logic [3:0] {
        st_boot,
        st_issue,       // draw_req high, waiting for ack
        st_release,     // draw_req low, waiting for ack to drop
        st_idle,        // wait for go
        st_frame,       // frame wait
        st_update       // one-cycle game update
    } ctrl_state_t;

    typedef enum logic [1:0] {
        op_clear,
        op_mole,
        op_hammer,
        op_erase
    } draw_op_t;

    typedef logic [1:0] slot_t;
    typedef logic [1:0] difficulty_t;  // 0 slow, 1 medium, 2 fast, 3 as slow
    typedef logic [7:0] score_t;

endpackage

// ==== design/game_settings.svh ====
`ifndef GAME_SETTINGS_SVH
`define GAME_SETTINGS_SVH

// frame buffer geometry
`define SCREEN_W        160
`define SCREEN_H        120
`define SKY_ROWS        60    // rows above the ground line

// left column of each hole
`define MOLE_X_0        19
`define MOLE_X_1        43
`define MOLE_X_2        67
`define MOLE_X_3        91

`define MOLE_Y_START    59    // hidden top row
`define MOLE_Y_END      51    // fully raised top row
`define HAMMER_Y        47    // top row of hammer and erase areas

`define MOLE_SIZE       8
`define HAMMER_SIZE     4
`define ERASE_ROWS      20

// pop-up patterns, msb first, 1 sends the mole up
`define SEQ_0           24'b110000111100101100110000
`define SEQ_1           24'b110011000110011110110011
`define SEQ_2           24'b000110011011000111001100
`define SEQ_3           24'b001101100110110011011011

`define TICK_CYCLES_DEFAULT 833333  // one tick per 60 Hz frame at 50 MHz

`endif

// ==== design/mole_field.sv ====
`timescale 1ns/1ps
`include "game_settings.svh"

module mole_field import game_pkg::*; import pixel_pkg::*; (
    input  logic       clk,
    input  logic       resetn,
    input  logic       update,
    input  logic [3:0] whack,
    output y_coord_t   mole_top [4],
    output logic [3:0] hammer_hits,
    output score_t     score
);

    localparam logic [23:0] seq_init [4] = '{`SEQ_0, `SEQ_1, `SEQ_2, `SEQ_3};
    localparam y_coord_t    y_start = y_coord_t'(`MOLE_Y_START);
    localparam y_coord_t    y_end   = y_coord_t'(`MOLE_Y_END);

    logic [23:0] seq [4];
    logic [3:0]  dir;          // 1 = moving up
    logic [3:0]  pend_hammer;  // whacks since last update
    logic [3:0]  pend_hit;     // whacks on a raised mole
    logic [2:0]  hit_count;

    always_comb begin
        hit_count = '0;
        for (int i = 0; i < 4; i++) begin
            hit_count = hit_count + 3'(pend_hit[i]);
        end
    end

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            score       <= '0;
            hammer_hits <= '0;
            pend_hammer <= '0;
            pend_hit    <= '0;
            dir         <= '0;
            for (int i = 0; i < 4; i++) begin
                mole_top[i] <= y_start;
                seq[i]      <= seq_init[i];
            end
        end else if (update) begin
            score       <= score + score_t'(hit_count);
            hammer_hits <= pend_hammer;
            pend_hammer <= '0;
            pend_hit    <= '0;
            for (int i = 0; i < 4; i++) begin
                // new direction, takes effect next update
                if (mole_top[i] == y_start) begin
                    dir[i] <= seq[i][23];
                    seq[i] <= {seq[i][22:0], 1'b0};
                end else if (mole_top[i] == y_end) begin
                    dir[i] <= 1'b0;
                end
                // step with the old direction
                if (dir[i] && mole_top[i] > y_end) begin
                    mole_top[i] <= mole_top[i] - 7'd1;
                end else if (!dir[i] && mole_top[i] < y_start) begin
                    mole_top[i] <= mole_top[i] + 7'd1;
                end
            end
        end else begin
            for (int i = 0; i < 4; i++) begin
                if (whack[i]) begin
                    pend_hammer[i] <= 1'b1;
                    if (mole_top[i] == y_end) begin
                        pend_hit[i] <= 1'b1;
                    end
                end
            end
        end
    end

endmodule

// ==== design/mole_game_top.sv ====
`timescale 1ns/1ps
`include "game_settings.svh"

module mole_game_top import game_pkg::*; import pixel_pkg::*; #(
    parameter int tick_cycles = `TICK_CYCLES_DEFAULT
) (
    input  logic        clk,
    input  logic        resetn,
    input  logic        go,
    input  difficulty_t difficulty,
    input  logic [3:0]  whack,
    output logic        plot,
    output x_coord_t    pix_x,
    output y_coord_t    pix_y,
    output colour_t     pix_colour,
    output score_t      score
);

    logic       draw_req;
    logic       draw_ack;
    draw_op_t   draw_op;
    slot_t      draw_slot;
    logic       update;
    logic       frame_run;
    logic       frame_done;
    y_coord_t   mole_top [4];
    logic [3:0] hammer_hits;

    game_control game_control_i (
        .clk        (clk),
        .resetn     (resetn),
        .go         (go),
        .draw_ack   (draw_ack),
        .frame_done (frame_done),
        .draw_req   (draw_req),
        .draw_op    (draw_op),
        .draw_slot  (draw_slot),
        .update     (update),
        .frame_run  (frame_run)
    );

    sprite_plotter sprite_plotter_i (
        .clk         (clk),
        .resetn      (resetn),
        .draw_req    (draw_req),
        .draw_op     (draw_op),
        .draw_slot   (draw_slot),
        .mole_top    (mole_top),
        .hammer_hits (hammer_hits),
        .draw_ack    (draw_ack),
        .plot        (plot),
        .pix_x       (pix_x),
        .pix_y       (pix_y),
        .pix_colour  (pix_colour)
    );

    mole_field mole_field_i (
        .clk         (clk),
        .resetn      (resetn),
        .update      (update),
        .whack       (whack),
        .mole_top    (mole_top),
        .hammer_hits (hammer_hits),
        .score       (score)
    );

    frame_timer #(
        .tick_cycles (tick_cycles)
    ) frame_timer_i (
        .clk        (clk),
        .resetn     (resetn),
        .frame_run  (frame_run),
        .difficulty (difficulty),
        .frame_done (frame_done)
    );

endmodule

// ==== design/pixel_pkg.sv ====
package pixel_pkg;

    typedef logic [7:0] x_coord_t;   // 0..159
    typedef logic [6:0] y_coord_t;   // 0..119
    typedef logic [2:0] colour_t;    // {r, g, b}

    localparam colour_t white  = 3'b111;
    localparam colour_t yellow = 3'b110;
    localparam colour_t red    = 3'b100;
    localparam colour_t cyan   = 3'b011;
    localparam colour_t black  = 3'b000;

endpackage

// ==== design/sprite_plotter.sv ====
`timescale 1ns/1ps
`include "game_settings.svh"

module sprite_plotter import game_pkg::*; import pixel_pkg::*; (
    input  logic       clk,
    input  logic       resetn,
    input  logic       draw_req,
    input  draw_op_t   draw_op,
    input  slot_t      draw_slot,
    input  y_coord_t   mole_top [4],
    input  logic [3:0] hammer_hits,
    output logic       draw_ack,
    output logic       plot,
    output x_coord_t   pix_x,
    output y_coord_t   pix_y,
    output colour_t    pix_colour
);

    localparam x_coord_t slot_x [4] = '{
        x_coord_t'(`MOLE_X_0),
        x_coord_t'(`MOLE_X_1),
        x_coord_t'(`MOLE_X_2),
        x_coord_t'(`MOLE_X_3)
    };
    localparam y_coord_t hammer_y  = y_coord_t'(`HAMMER_Y);
    localparam y_coord_t erase_sky = y_coord_t'(`SKY_ROWS - `HAMMER_Y); // sky part of erase

    x_coord_t off_x;
    y_coord_t off_y;
    x_coord_t col_last;
    y_coord_t row_last;
    x_coord_t base_x;
    y_coord_t base_y;
    logic     busy;
    logic     last_pix;

    // shape extent
    always_comb begin
        case (draw_op)
            op_clear: begin
                col_last = x_coord_t'(`SCREEN_W - 1);
                row_last = y_coord_t'(`SCREEN_H - 1);
            end
            op_mole: begin
                col_last = x_coord_t'(`MOLE_SIZE - 1);
                row_last = y_coord_t'(`MOLE_SIZE - 1);
            end
            op_hammer: begin
                col_last = x_coord_t'(`HAMMER_SIZE - 1);
                row_last = y_coord_t'(`HAMMER_SIZE - 1);
            end
            default: begin
                col_last = x_coord_t'(`MOLE_SIZE - 1);
                row_last = y_coord_t'(`ERASE_ROWS - 1);
            end
        endcase
    end

    // shape origin
    always_comb begin
        base_x = (draw_op == op_clear) ? '0 : slot_x[draw_slot];
        case (draw_op)
            op_clear: base_y = '0;
            op_mole:  base_y = mole_top[draw_slot];
            default:  base_y = hammer_y;
        endcase
    end

    assign last_pix = (off_x == col_last) && (off_y == row_last);

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            busy     <= 1'b0;
            draw_ack <= 1'b0;
            off_x    <= '0;
            off_y    <= '0;
        end else if (busy) begin
            if (last_pix) begin
                busy     <= 1'b0;
                draw_ack <= 1'b1;
                off_x    <= '0;
                off_y    <= '0;
            end else if (draw_op == op_clear) begin
                // raster order
                if (off_x == col_last) begin
                    off_x <= '0;
                    off_y <= off_y + 7'd1;
                end else begin
                    off_x <= off_x + 8'd1;
                end
            end else begin
                // column by column, row is the fast index
                if (off_y == row_last) begin
                    off_y <= '0;
                    off_x <= off_x + 8'd1;
                end else begin
                    off_y <= off_y + 7'd1;
                end
            end
        end else if (draw_ack) begin
            if (!draw_req) begin
                draw_ack <= 1'b0;
            end
        end else if (draw_req) begin
            busy <= 1'b1;
        end
    end

    assign plot  = busy;
    assign pix_x = base_x + off_x;
    assign pix_y = base_y + off_y;

    always_comb begin
        case (draw_op)
            op_clear: begin
                pix_colour = (off_y < y_coord_t'(`SKY_ROWS)) ? white : black;
            end
            op_mole: begin
                if (off_y >= 7'd6) begin
                    pix_colour = black;     // shadow rows
                end else if (off_y == 7'd0 && off_x inside {0, 3, 4, 7}) begin
                    pix_colour = white;     // ears
                end else if ((off_y == 7'd2 || off_y == 7'd3) && off_x inside {2, 5}) begin
                    pix_colour = black;     // eyes
                end else if (off_y == 7'd5 && off_x inside {3, 4}) begin
                    pix_colour = red;       // mouth
                end else begin
                    pix_colour = yellow;
                end
            end
            op_hammer: begin
                pix_colour = hammer_hits[draw_slot] ? cyan : black;
            end
            default: begin
                pix_colour = (off_y < erase_sky) ? white : black;
            end
        endcase
    end

endmodule

// ==== verification/mole_game_sva.sv ====
`timescale 1ns/1ps

module mole_game_sva import game_pkg::*; (
    input logic     clk,
    input logic     resetn,
    input logic     draw_req,
    input logic     draw_ack,
    input draw_op_t draw_op,
    input score_t   score
);

    int fail_count = 0;  // assertion failures so far

    ack_needs_req: assert property (@(posedge clk) disable iff (!resetn)
        $rose(draw_ack) |-> draw_req)
        else begin
            fail_count++;
            $error("draw_ack rose with no draw_req pending");
        end

    req_held: assert property (@(posedge clk) disable iff (!resetn)
        draw_req && !draw_ack |=> draw_req)
        else begin
            fail_count++;
            $error("draw_req dropped before draw_ack");
        end

    op_stable: assert property (@(posedge clk) disable iff (!resetn)
        draw_req && $past(draw_req) |-> $stable(draw_op))
        else begin
            fail_count++;
            $error("draw_op changed during a request");
        end

    score_rises: assert property (@(posedge clk) disable iff (!resetn)
        score >= $past(score))
        else begin
            fail_count++;
            $error("score decreased");
        end

endmodule

// handshake wires and score both live in the top level
bind mole_game_top mole_game_sva mole_game_sva_i (
    .clk(clk), .resetn(resetn), .draw_req(draw_req), .draw_ack(draw_ack),
    .draw_op(draw_op), .score(score)
);

// ==== verification/mole_game_tb.sv ====
`timescale 1ns/1ps
`include "game_settings.svh"

module mole_game_tb import game_pkg::*, pixel_pkg::*; ();

    localparam int  tick_cycles  = 4;
    localparam int  num_rounds   = 12;
    localparam int  clear_pixels = `SCREEN_W * `SCREEN_H;
    localparam int  round_cycles = 4 * (`MOLE_SIZE * (`MOLE_SIZE + `ERASE_ROWS)
                                   + `HAMMER_SIZE * `HAMMER_SIZE) + 15 * tick_cycles + 100;
    localparam time timeout_ns   = 40 * (clear_pixels + 100 + num_rounds * round_cycles);

    logic        clk, resetn, go, plot;
    difficulty_t difficulty;
    logic [3:0]  whack;
    x_coord_t    pix_x;
    y_coord_t    pix_y;
    colour_t     pix_colour;
    score_t      score;

    logic [23:0] seq_m [4];
    y_coord_t    top_m [4];
    logic [3:0]  dir_m, hits_m, prev_whack, cur_whack;  // model state
    score_t      score_m;
    draw_op_t    phase;                                 // shape expected in the pixel stream
    slot_t       slot;
    int          pix_idx, cycle, last_mole_cycle, frames_m, round;
    int          checks, errors, round_errors, tests, tests_failed;
    bit          done;
    integer      seed;

    mole_game_top #(.tick_cycles(tick_cycles)) mole_game_top_i (
        .clk(clk), .resetn(resetn), .go(go), .difficulty(difficulty), .whack(whack),
        .plot(plot), .pix_x(pix_x), .pix_y(pix_y), .pix_colour(pix_colour), .score(score)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;

    function automatic x_coord_t slot_col(slot_t s);
        case (s)
            2'd0:    return x_coord_t'(`MOLE_X_0);
            2'd1:    return x_coord_t'(`MOLE_X_1);
            2'd2:    return x_coord_t'(`MOLE_X_2);
            default: return x_coord_t'(`MOLE_X_3);
        endcase
    endfunction

    function automatic colour_t mole_colour(int col, int row);
        if (row >= 6) return black;
        if (row == 0 && (col == 0 || col == 3 || col == 4 || col == 7)) return white;
        if ((row == 2 || row == 3) && (col == 2 || col == 5)) return black;
        if (row == 5 && (col == 3 || col == 4)) return red;
        return yellow;
    endfunction

    function automatic int shape_pixels(draw_op_t op);
        case (op)
            op_clear:  return clear_pixels;
            op_mole:   return `MOLE_SIZE * `MOLE_SIZE;
            op_hammer: return `HAMMER_SIZE * `HAMMER_SIZE;
            default:   return `MOLE_SIZE * `ERASE_ROWS;
        endcase
    endfunction

    task automatic check_pixel(x_coord_t got_x, y_coord_t got_y, colour_t got_c,
                               x_coord_t exp_x, y_coord_t exp_y, colour_t exp_c);
        checks++;
        if (got_x !== exp_x || got_y !== exp_y || got_c !== exp_c) begin
            errors++;
            round_errors++;
            $display("FAILED at %0t: %s slot %0d pixel %0d (%0d,%0d) col %0d, want (%0d,%0d) %0d",
                     $time, phase.name(), slot, pix_idx, got_x, got_y, got_c, exp_x, exp_y, exp_c);
        end
    endtask

    task automatic check_score(score_t got, score_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            round_errors++;
            $display("FAILED at %0t: score is %0d, expected %0d", $time, got, exp);
        end
    endtask

    task automatic check_gap(int got, int lo, int hi);
        checks++;
        if (got < lo || got > hi) begin
            errors++;
            round_errors++;
            $display("FAILED at %0t: frame wait took %0d cycles, expected %0d to %0d",
                     $time, got, lo, hi);
        end
    endtask

    // last round's whack is still applied during the hammer draw, so both reach the flags
    task automatic apply_update();
        logic old_dir;
        hits_m = prev_whack | cur_whack;
        for (int i = 0; i < 4; i++) begin
            if (hits_m[i] && top_m[i] == `MOLE_Y_END) score_m = score_m + 8'd1;
            old_dir = dir_m[i];
            if (top_m[i] == `MOLE_Y_START) begin
                dir_m[i] = seq_m[i][23];
                seq_m[i] = seq_m[i] << 1;
            end else if (top_m[i] == `MOLE_Y_END) begin
                dir_m[i] = 1'b0;
            end
            if (old_dir && top_m[i] > `MOLE_Y_END) top_m[i] = top_m[i] - 7'd1;
            else if (!old_dir && top_m[i] < `MOLE_Y_START) top_m[i] = top_m[i] + 7'd1;
        end
        prev_whack = cur_whack;
    endtask

    task automatic start_shape();
        difficulty_t next_diff;
        if (phase == op_mole && slot == 2'd0) begin
            cur_whack  = 4'($random(seed));
            next_diff  = 2'($random(seed));
            whack      <= cur_whack;
            difficulty <= next_diff;
            frames_m   = (next_diff == 2'd1) ? 10 : (next_diff == 2'd2) ? 5 : 15;
        end else if (phase == op_erase && slot == 2'd0) begin
            check_gap(cycle - last_mole_cycle, frames_m * tick_cycles,
                      frames_m * tick_cycles + 4);
        end else if (phase == op_hammer && slot == 2'd0) begin
            apply_update();
            check_score(score, score_m);
        end
    endtask

    task automatic check_current();
        int col;
        int row;
        case (phase)
            op_clear: begin
                col = pix_idx % `SCREEN_W;   // raster order
                row = pix_idx / `SCREEN_W;
                check_pixel(pix_x, pix_y, pix_colour, x_coord_t'(col), y_coord_t'(row),
                            (row < `SKY_ROWS) ? white : black);
            end
            op_mole: begin
                col = pix_idx / `MOLE_SIZE;  // row is the fast index
                row = pix_idx % `MOLE_SIZE;
                check_pixel(pix_x, pix_y, pix_colour, slot_col(slot) + x_coord_t'(col),
                            top_m[slot] + y_coord_t'(row), mole_colour(col, row));
            end
            op_hammer: begin
                col = pix_idx / `HAMMER_SIZE;
                row = pix_idx % `HAMMER_SIZE;
                check_pixel(pix_x, pix_y, pix_colour, slot_col(slot) + x_coord_t'(col),
                            y_coord_t'(`HAMMER_Y + row), hits_m[slot] ? cyan : black);
            end
            default: begin
                col = pix_idx / `ERASE_ROWS;
                row = pix_idx % `ERASE_ROWS;
                check_pixel(pix_x, pix_y, pix_colour, slot_col(slot) + x_coord_t'(col),
                            y_coord_t'(`HAMMER_Y + row),
                            (row < `SKY_ROWS - `HAMMER_Y) ? white : black);
            end
        endcase
    endtask

    task automatic report_test(string name);
        tests++;
        if (round_errors != 0) tests_failed++;
        $display("%s: %s, %0d errors", name, (round_errors == 0) ? "pass" : "fail", round_errors);
        round_errors = 0;
    endtask

    task automatic finish_shape();
        pix_idx = 0;
        if (phase == op_clear) begin
            report_test("clear screen");
            phase = op_mole;
        end else if (slot != 2'd3) begin
            slot = slot + 2'd1;
        end else begin
            slot = 2'd0;
            if (phase == op_mole) begin
                last_mole_cycle = cycle;
                phase = op_erase;
            end else if (phase == op_erase) begin
                phase = op_hammer;
            end else begin
                report_test($sformatf("round %0d (%0d frames, whack %b, score %0d)",
                                      round, frames_m, cur_whack, score_m));
                round++;
                done  = (round > num_rounds);
                phase = op_mole;
            end
        end
    endtask

    always @(posedge clk) begin
        cycle++;
        if (resetn && plot && !done) begin
            if (pix_idx == 0) start_shape();
            check_current();
            pix_idx++;
            if (pix_idx == shape_pixels(phase)) finish_shape();
        end
    end

    initial begin
        seed       = 32'h91c1_b566;
        resetn     = 1'b0;
        go         = 1'b1;
        difficulty = '0;
        whack      = '0;
        seq_m      = '{`SEQ_0, `SEQ_1, `SEQ_2, `SEQ_3};
        top_m      = '{default: y_coord_t'(`MOLE_Y_START)};
        {dir_m, hits_m, prev_whack, cur_whack} = '0;
        score_m    = '0;
        phase      = op_clear;
        slot       = '0;
        {pix_idx, cycle, last_mole_cycle, checks, errors, round_errors, tests, tests_failed} = '0;
        frames_m   = 15;
        round      = 1;
        done       = 1'b0;
        repeat (3) @(posedge clk);
        resetn <= 1'b1;
    end

    initial begin
        #(timeout_ns);
        $display("run timed out after %0t, the pixel stream stalled in round %0d", $time, round);
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        wait (done);
        @(posedge clk);
        errors = errors + mole_game_top_i.mole_game_sva_i.fail_count;
        $display("%0d tests, %0d failed, %0d checks, %0d errors",
                 tests, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== vlog.f ====
+incdir+design
design/game_pkg.sv
design/pixel_pkg.sv
design/game_control.sv
design/sprite_plotter.sv
design/mole_field.sv
design/frame_timer.sv
design/mole_game_top.sv
verification/mole_game_sva.sv
verification/mole_game_tb.sv
